/* logic/phy_clock_pkg.sv */
// phy clock package: reset synchronizer depths and copy counts for the PHY clock domains

package phy_clock_pkg;

	// number of flip-flops in one reset synchronizer chain
	typedef logic [4:0] sync_stage_t;

	// depth used for every full-rate PHY clock domain
	// (AFI, controller, address/command, resync, sequencer, scan chain and
	// each read-capture DQS clock)
	localparam sync_stage_t DEFAULT_SYNC_STAGES = 5'd15;

	// the Avalon management port sees a slow clock, so a short chain is enough
	// and keeps the management interface usable soon after the PLL locks
	localparam sync_stage_t DEFAULT_AVL_SYNC_STAGES = 5'd2;

	// copies of the AFI-domain reset, each driven from its own final flop
	// so that large fan-outs can be split across regions
	localparam int DEFAULT_NUM_AFI_RESET = 1;

endpackage

/* logic/phy_seq_pkg.sv */
// phy sequencer package: memory power-up timer states, counter type and default wait

package phy_seq_pkg;

	// states of the memory power-up timer
	// INIT_IDLE   first cycle after the sequencer reset is released
	// INIT_WAIT   counting out the power-up wait
	// INIT_STABLE the memory supply and clock are considered stable
	typedef enum logic [1:0]
	{
		INIT_IDLE,
		INIT_WAIT,
		INIT_STABLE
	} init_state_t;

	// count of sequencer clock cycles
	typedef logic [15:0] init_count_t;

	// default power-up wait, in sequencer clock cycles
	// scale this with the sequencer clock frequency to meet the DRAM's
	// stable-power requirement before the read-capture logic is released
	localparam init_count_t DEFAULT_MEM_INIT_CYCLES = 16'd200;

endpackage

/* logic/reset_sync.sv */
// reset synchronizer: asynchronous assert, synchronous deassert, several local output copies

`timescale 1ns/1ps

module reset_sync
	import phy_clock_pkg::*;
#(
	parameter sync_stage_t STAGES = DEFAULT_SYNC_STAGES,
	parameter int NUM_OUTPUT = 1
)
(
	input logic clk,
	input logic reset_n,
	output logic [NUM_OUTPUT-1:0] reset_n_sync
);

	// the shared part of the chain holds STAGES-1 flops, the last stage is
	// duplicated once per output copy
	localparam int CHAIN_LEN = int'(STAGES) - 1;

	logic [CHAIN_LEN-1:0] sync_chain;

	// shared stages shift a one in from the front after the source rises
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			sync_chain <= '0;
		end
		else
		begin
			sync_chain[0] <= 1'b1;
			for (int i = 1; i < CHAIN_LEN; i++)
			begin
				sync_chain[i] <= sync_chain[i-1];
			end
		end
	end

	// each copy is a separate flop fed from the last shared stage, so the
	// copies can be placed next to their own loads
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			reset_n_sync <= '0;
		end
		else
		begin
			for (int j = 0; j < NUM_OUTPUT; j++)
			begin
				reset_n_sync[j] <= sync_chain[CHAIN_LEN-1];
			end
		end
	end

endmodule

/* logic/mem_init_timer.sv */
// memory init timer: raises the memory-stable flag once the power-up wait has elapsed

`timescale 1ns/1ps

module mem_init_timer
	import phy_seq_pkg::*;
#(
	parameter init_count_t MEM_INIT_CYCLES = DEFAULT_MEM_INIT_CYCLES
)
(
	input logic seq_clk,
	input logic reset_n_seq_clk,
	output logic mem_stable
);

	// value the counter holds at the edge that ends the wait
	// the IDLE edge counts as the first cycle of the wait
	localparam init_count_t WAIT_LAST = MEM_INIT_CYCLES - init_count_t'(1);

	init_state_t state;
	init_state_t next_state;
	init_count_t wait_count;
	logic wait_done;

	// the counter holds the number of edges seen since reset was released
	assign wait_done = (wait_count == WAIT_LAST);

	always_comb
	begin
		next_state = state;
		case (state)
			INIT_IDLE:
			begin
				// a wait of a single cycle ends on this first edge
				if (MEM_INIT_CYCLES <= init_count_t'(1))
				begin
					next_state = INIT_STABLE;
				end
				else
				begin
					next_state = INIT_WAIT;
				end
			end
			INIT_WAIT:
			begin
				if (wait_done)
				begin
					next_state = INIT_STABLE;
				end
			end
			INIT_STABLE:
			begin
				// only a new sequencer reset leaves this state
				next_state = INIT_STABLE;
			end
			default:
			begin
				next_state = INIT_IDLE;
			end
		endcase
	end

	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			state <= INIT_IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	// the counter only advances while waiting
	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			wait_count <= '0;
		end
		else if (state == INIT_IDLE)
		begin
			wait_count <= init_count_t'(1);
		end
		else if (state == INIT_WAIT && !wait_done)
		begin
			wait_count <= wait_count + init_count_t'(1);
		end
	end

	// decoded straight from the state register, so it drops with the async clear
	assign mem_stable = (state == INIT_STABLE);

endmodule

/* logic/phy_reset.sv */
// phy reset tree: combines the reset sources and synchronizes the result into each PHY clock domain

`timescale 1ns/1ps

module phy_reset
	import phy_clock_pkg::*;
#(
	parameter int NUM_DQS = 4,
	parameter int NUM_AFI_RESET = DEFAULT_NUM_AFI_RESET,
	parameter sync_stage_t SYNC_STAGES = DEFAULT_SYNC_STAGES,
	parameter sync_stage_t AVL_SYNC_STAGES = DEFAULT_AVL_SYNC_STAGES
)
(
	// clocks of the PHY domains
	input logic pll_afi_clk,
	input logic pll_addr_cmd_clk,
	input logic pll_dqs_ena_clk,
	input logic seq_clk,
	input logic scc_clk,
	input logic pll_avl_clk,
	input logic [NUM_DQS-1:0] read_capture_clk,

	// reset sources and the memory-stable status from the sequencer
	input logic pll_locked,
	input logic rst_n,
	input logic soft_reset_n,
	input logic mem_stable,

	// synchronized resets, all active low
	output logic [NUM_AFI_RESET-1:0] reset_n_afi_clk,
	output logic ctl_reset_n,
	output logic ctl_reset_export_n,
	output logic reset_n_addr_cmd_clk,
	output logic reset_n_resync_clk,
	output logic reset_n_seq_clk,
	output logic reset_n_scc_clk,
	output logic reset_n_avl_clk,
	output logic [NUM_DQS-1:0] reset_n_read_capture_clk
);

	logic phy_reset_n;
	logic phy_reset_mem_stable_n;

	// any one source holds the whole PHY in reset
	assign phy_reset_n = rst_n & pll_locked & soft_reset_n;

	// the read-capture logic also waits for the memory power-up time
	assign phy_reset_mem_stable_n = phy_reset_n & mem_stable;

	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (NUM_AFI_RESET)
	) reset_sync_afi_inst (
		.clk (pll_afi_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_afi_clk)
	);

	// one synchronizer with two copies, so the controller and its export
	// always release on the same AFI edge
	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (2)
	) reset_sync_ctl_inst (
		.clk (pll_afi_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync ({ctl_reset_n, ctl_reset_export_n})
	);

	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (1)
	) reset_sync_addr_cmd_inst (
		.clk (pll_addr_cmd_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_addr_cmd_clk)
	);

	// the resync domain runs on the DQS enable clock
	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (1)
	) reset_sync_resync_inst (
		.clk (pll_dqs_ena_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_resync_clk)
	);

	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (1)
	) reset_sync_seq_inst (
		.clk (seq_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_seq_clk)
	);

	reset_sync #(
		.STAGES (SYNC_STAGES),
		.NUM_OUTPUT (1)
	) reset_sync_scc_inst (
		.clk (scc_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_scc_clk)
	);

	reset_sync #(
		.STAGES (AVL_SYNC_STAGES),
		.NUM_OUTPUT (1)
	) reset_sync_avl_inst (
		.clk (pll_avl_clk),
		.reset_n (phy_reset_n),
		.reset_n_sync (reset_n_avl_clk)
	);

	// one synchronizer per DQS group, each in its own capture clock domain
	for (genvar i = 0; i < NUM_DQS; i++)
	begin : read_capture_reset
		reset_sync #(
			.STAGES (SYNC_STAGES),
			.NUM_OUTPUT (1)
		) reset_sync_read_capture_inst (
			.clk (read_capture_clk[i]),
			.reset_n (phy_reset_mem_stable_n),
			.reset_n_sync (reset_n_read_capture_clk[i])
		);
	end

endmodule

/* logic/phy_reset_top.sv */
// phy reset top: reset tree plus the sequencer-domain memory-stable timer

`timescale 1ns/1ps

module phy_reset_top
	import phy_clock_pkg::*;
	import phy_seq_pkg::*;
#(
	parameter int NUM_DQS = 4,
	parameter int NUM_AFI_RESET = DEFAULT_NUM_AFI_RESET,
	parameter sync_stage_t SYNC_STAGES = DEFAULT_SYNC_STAGES,
	parameter sync_stage_t AVL_SYNC_STAGES = DEFAULT_AVL_SYNC_STAGES,
	parameter init_count_t MEM_INIT_CYCLES = DEFAULT_MEM_INIT_CYCLES
)
(
	input logic pll_afi_clk,
	input logic pll_addr_cmd_clk,
	input logic pll_dqs_ena_clk,
	input logic seq_clk,
	input logic scc_clk,
	input logic pll_avl_clk,
	input logic [NUM_DQS-1:0] read_capture_clk,

	input logic pll_locked,
	input logic rst_n,
	input logic soft_reset_n,

	output logic [NUM_AFI_RESET-1:0] reset_n_afi_clk,
	output logic ctl_reset_n,
	output logic ctl_reset_export_n,
	output logic reset_n_addr_cmd_clk,
	output logic reset_n_resync_clk,
	output logic reset_n_seq_clk,
	output logic reset_n_scc_clk,
	output logic reset_n_avl_clk,
	output logic [NUM_DQS-1:0] reset_n_read_capture_clk,
	output logic mem_init_done
);

	// the timer runs from the synchronized sequencer reset and its flag
	// gates the read-capture resets inside the tree
	phy_reset #(
		.NUM_DQS (NUM_DQS),
		.NUM_AFI_RESET (NUM_AFI_RESET),
		.SYNC_STAGES (SYNC_STAGES),
		.AVL_SYNC_STAGES (AVL_SYNC_STAGES)
	) phy_reset_inst (
		.pll_afi_clk (pll_afi_clk),
		.pll_addr_cmd_clk (pll_addr_cmd_clk),
		.pll_dqs_ena_clk (pll_dqs_ena_clk),
		.seq_clk (seq_clk),
		.scc_clk (scc_clk),
		.pll_avl_clk (pll_avl_clk),
		.read_capture_clk (read_capture_clk),
		.pll_locked (pll_locked),
		.rst_n (rst_n),
		.soft_reset_n (soft_reset_n),
		.mem_stable (mem_init_done),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ctl_reset_n (ctl_reset_n),
		.ctl_reset_export_n (ctl_reset_export_n),
		.reset_n_addr_cmd_clk (reset_n_addr_cmd_clk),
		.reset_n_resync_clk (reset_n_resync_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.reset_n_avl_clk (reset_n_avl_clk),
		.reset_n_read_capture_clk (reset_n_read_capture_clk)
	);

	mem_init_timer #(
		.MEM_INIT_CYCLES (MEM_INIT_CYCLES)
	) mem_init_timer_inst (
		.seq_clk (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.mem_stable (mem_init_done)
	);

endmodule

/* testbench/phy_reset_tb.sv */
// phy reset testbench: drives the reset sources and checks every output against an edge-count model

`timescale 1ns/1ps

module phy_reset_tb;

	localparam int NUM_DQS = 4;
	localparam int NUM_AFI_RESET = 1;
	localparam int SYNC = 15;
	localparam int AVL_SYNC = 2;
	localparam int MEM_INIT = 20;
	localparam int SAT = 1000;

	// lengths in AFI cycles used to bound the run
	localparam int FULL_CYCLES = 120;
	localparam int ROUND_CYCLES = 8 + 12 + 40;
	localparam int NUM_ROUNDS = 20;
	localparam int TIMEOUT_NS = (5 + 4 * FULL_CYCLES + NUM_ROUNDS * ROUND_CYCLES) * 100 + 10000;

	logic pll_afi_clk = 1'b0;
	logic pll_addr_cmd_clk = 1'b0;
	logic pll_dqs_ena_clk = 1'b0;
	logic seq_clk = 1'b0;
	logic scc_clk = 1'b0;
	logic pll_avl_clk = 1'b0;
	logic [NUM_DQS-1:0] read_capture_clk = '0;
	logic pll_locked;
	logic rst_n;
	logic soft_reset_n;

	logic [NUM_AFI_RESET-1:0] reset_n_afi_clk;
	logic ctl_reset_n;
	logic ctl_reset_export_n;
	logic reset_n_addr_cmd_clk;
	logic reset_n_resync_clk;
	logic reset_n_seq_clk;
	logic reset_n_scc_clk;
	logic reset_n_avl_clk;
	logic [NUM_DQS-1:0] reset_n_read_capture_clk;
	logic mem_init_done;

	integer seed;

	phy_reset_top #(
		.NUM_DQS (NUM_DQS),
		.NUM_AFI_RESET (NUM_AFI_RESET),
		.SYNC_STAGES (5'd15),
		.AVL_SYNC_STAGES (5'd2),
		.MEM_INIT_CYCLES (16'd20)
	) phy_reset_top_inst (
		.pll_afi_clk (pll_afi_clk),
		.pll_addr_cmd_clk (pll_addr_cmd_clk),
		.pll_dqs_ena_clk (pll_dqs_ena_clk),
		.seq_clk (seq_clk),
		.scc_clk (scc_clk),
		.pll_avl_clk (pll_avl_clk),
		.read_capture_clk (read_capture_clk),
		.pll_locked (pll_locked),
		.rst_n (rst_n),
		.soft_reset_n (soft_reset_n),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ctl_reset_n (ctl_reset_n),
		.ctl_reset_export_n (ctl_reset_export_n),
		.reset_n_addr_cmd_clk (reset_n_addr_cmd_clk),
		.reset_n_resync_clk (reset_n_resync_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.reset_n_avl_clk (reset_n_avl_clk),
		.reset_n_read_capture_clk (reset_n_read_capture_clk),
		.mem_init_done (mem_init_done)
	);

	// phase offsets keep every edge of one domain away from the others
	initial
	begin
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end
	initial
	begin
		#10;
		forever #50 pll_addr_cmd_clk = ~pll_addr_cmd_clk;
	end
	initial
	begin
		#20;
		forever #50 pll_dqs_ena_clk = ~pll_dqs_ena_clk;
	end
	initial
	begin
		#5;
		forever #100 seq_clk = ~seq_clk;
	end
	initial
	begin
		#15;
		forever #100 scc_clk = ~scc_clk;
	end
	initial
	begin
		#25;
		forever #100 pll_avl_clk = ~pll_avl_clk;
	end
	for (genvar g = 0; g < NUM_DQS; g++)
	begin : capture_clock
		initial
		begin
			#(30 + 5 * g);
			forever #50 read_capture_clk[g] = ~read_capture_clk[g];
		end
	end

	// an output is released once its own clock has counted enough edges
	// while its source was high
	function automatic logic expected_level(input int edges, input int stages);
		return (edges >= stages) ? 1'b1 : 1'b0;
	endfunction

	logic phy_src;
	logic exp_mem_done;
	logic rc_src;
	int afi_cnt = 0;
	int addr_cmd_cnt = 0;
	int resync_cnt = 0;
	int seq_cnt = 0;
	int scc_cnt = 0;
	int avl_cnt = 0;
	int rc_cnt [NUM_DQS];

	assign phy_src = rst_n & pll_locked & soft_reset_n;
	// the memory flag follows the sequencer reset by the power-up wait
	assign exp_mem_done = expected_level(seq_cnt, SYNC + MEM_INIT);
	assign rc_src = phy_src & exp_mem_done;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Fail %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
		$display("*** FAILED ***");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	always @(posedge pll_afi_clk or negedge phy_src)
	begin
		if (!phy_src)
			afi_cnt <= 0;
		else if (afi_cnt < SAT)
			afi_cnt <= afi_cnt + 1;
	end
	always @(posedge pll_addr_cmd_clk or negedge phy_src)
	begin
		if (!phy_src)
			addr_cmd_cnt <= 0;
		else if (addr_cmd_cnt < SAT)
			addr_cmd_cnt <= addr_cmd_cnt + 1;
	end
	always @(posedge pll_dqs_ena_clk or negedge phy_src)
	begin
		if (!phy_src)
			resync_cnt <= 0;
		else if (resync_cnt < SAT)
			resync_cnt <= resync_cnt + 1;
	end
	always @(posedge seq_clk or negedge phy_src)
	begin
		if (!phy_src)
			seq_cnt <= 0;
		else if (seq_cnt < SAT)
			seq_cnt <= seq_cnt + 1;
	end
	always @(posedge scc_clk or negedge phy_src)
	begin
		if (!phy_src)
			scc_cnt <= 0;
		else if (scc_cnt < SAT)
			scc_cnt <= scc_cnt + 1;
	end
	always @(posedge pll_avl_clk or negedge phy_src)
	begin
		if (!phy_src)
			avl_cnt <= 0;
		else if (avl_cnt < SAT)
			avl_cnt <= avl_cnt + 1;
	end

	// outputs are sampled half a period before the next rising edge
	always @(negedge pll_afi_clk)
	begin
		check_value("reset_n_afi_clk", 32'({NUM_AFI_RESET{expected_level(afi_cnt, SYNC)}}),
			32'(reset_n_afi_clk));
		check_value("ctl_reset_n", 32'(expected_level(afi_cnt, SYNC)), 32'(ctl_reset_n));
		check_value("ctl_reset_export_n", 32'(expected_level(afi_cnt, SYNC)),
			32'(ctl_reset_export_n));
	end
	always @(negedge pll_addr_cmd_clk)
		check_value("reset_n_addr_cmd_clk", 32'(expected_level(addr_cmd_cnt, SYNC)),
			32'(reset_n_addr_cmd_clk));
	always @(negedge pll_dqs_ena_clk)
		check_value("reset_n_resync_clk", 32'(expected_level(resync_cnt, SYNC)),
			32'(reset_n_resync_clk));
	always @(negedge seq_clk)
	begin
		check_value("reset_n_seq_clk", 32'(expected_level(seq_cnt, SYNC)), 32'(reset_n_seq_clk));
		check_value("mem_init_done", 32'(exp_mem_done), 32'(mem_init_done));
	end
	always @(negedge scc_clk)
		check_value("reset_n_scc_clk", 32'(expected_level(scc_cnt, SYNC)), 32'(reset_n_scc_clk));
	always @(negedge pll_avl_clk)
		check_value("reset_n_avl_clk", 32'(expected_level(avl_cnt, AVL_SYNC)),
			32'(reset_n_avl_clk));

	for (genvar i = 0; i < NUM_DQS; i++)
	begin : capture_model
		initial rc_cnt[i] = 0;
		always @(posedge read_capture_clk[i] or negedge rc_src)
		begin
			if (!rc_src)
				rc_cnt[i] <= 0;
			else if (rc_cnt[i] < SAT)
				rc_cnt[i] <= rc_cnt[i] + 1;
		end
		always @(negedge read_capture_clk[i])
			check_value($sformatf("reset_n_read_capture_clk[%0d]", i),
				32'(expected_level(rc_cnt[i], SYNC)), 32'(reset_n_read_capture_clk[i]));
	end

	task automatic set_source(input int which, input logic level);
		case (which)
			0: rst_n = level;
			1: pll_locked = level;
			default: soft_reset_n = level;
		endcase
	endtask

	// every output must fall through the async clear without a clock edge
	task automatic check_all_low();
		#1;
		check_value("reset_n_afi_clk", 32'h0, 32'(reset_n_afi_clk));
		check_value("ctl_reset_n", 32'h0, 32'(ctl_reset_n));
		check_value("ctl_reset_export_n", 32'h0, 32'(ctl_reset_export_n));
		check_value("reset_n_addr_cmd_clk", 32'h0, 32'(reset_n_addr_cmd_clk));
		check_value("reset_n_resync_clk", 32'h0, 32'(reset_n_resync_clk));
		check_value("reset_n_seq_clk", 32'h0, 32'(reset_n_seq_clk));
		check_value("reset_n_scc_clk", 32'h0, 32'(reset_n_scc_clk));
		check_value("reset_n_avl_clk", 32'h0, 32'(reset_n_avl_clk));
		check_value("reset_n_read_capture_clk", 32'h0, 32'(reset_n_read_capture_clk));
		check_value("mem_init_done", 32'h0, 32'(mem_init_done));
	endtask

	task automatic wait_all_high();
		while (!(&reset_n_read_capture_clk && mem_init_done && reset_n_avl_clk
			&& reset_n_scc_clk && reset_n_resync_clk && reset_n_addr_cmd_clk && ctl_reset_n))
			@(negedge pll_afi_clk);
	endtask

	task automatic drop_and_release(input int which, input int hold);
		@(negedge pll_afi_clk);
		set_source(which, 1'b0);
		check_all_low();
		repeat (hold) @(negedge pll_afi_clk);
		set_source(which, 1'b1);
		wait_all_high();
	endtask

	task automatic random_round();
		int mask;
		int start;
		int hold;
		int src;
		mask = 1 + int'($unsigned($random(seed)) % 7);
		start = int'($unsigned($random(seed)) % 3);
		hold = 1 + int'($unsigned($random(seed)) % 8);
		@(negedge pll_afi_clk);
		for (int k = 0; k < 3; k++)
			if (mask[k])
				set_source(k, 1'b0);
		check_all_low();
		repeat (hold) @(negedge pll_afi_clk);
		// release in a random order with random gaps
		for (int j = 0; j < 3; j++)
		begin
			src = (start + j) % 3;
			if (mask[src])
			begin
				repeat (1 + int'($unsigned($random(seed)) % 4)) @(negedge pll_afi_clk);
				set_source(src, 1'b1);
			end
		end
		// a short wait can interrupt the synchronizers mid-release
		repeat (int'($unsigned($random(seed)) % 40)) @(negedge pll_afi_clk);
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the reset tree did not finish all tests in the expected time");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		seed = 49722;
		rst_n = 1'b0;
		pll_locked = 1'b0;
		soft_reset_n = 1'b1;
		repeat (5) @(negedge pll_afi_clk);
		pll_locked = 1'b1;
		@(negedge pll_afi_clk);
		rst_n = 1'b1;
		wait_all_high();
		drop_and_release(1, 3);
		drop_and_release(2, 5);
		for (int r = 0; r < NUM_ROUNDS; r++)
			random_round();
		wait_all_high();
		repeat (4) @(negedge pll_afi_clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* files.f */
logic/phy_clock_pkg.sv
logic/phy_seq_pkg.sv
logic/reset_sync.sv
logic/mem_init_timer.sv
logic/phy_reset.sv
logic/phy_reset_top.sv
testbench/phy_reset_tb.sv

/* Makefile */
# Verilator build for the PHY reset tree testbench

VERILATOR ?= verilator
TOP ?= phy_reset_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the log decides the result, since a fatal stop may not set the exit status
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
